// ==== build.f ====
logic/ram512k_pkg.sv
logic/bank_select_reg.sv
logic/block_mapper.sv
logic/cpld_ram512k.sv
logic/sram_512k.sv
logic/ram512k_card.sv
test/tb_clock_gen.sv
test/tb_ram512k_card.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the card testbench with Verilator and runs it, exit status is the simulator's
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_ram512k_card \
   -f build.f \
   -o sim_ram512k_card

./obj_dir/sim_ram512k_card

// ==== test/tb_ram512k_card.sv ====
// table-driven testbench for the 512k ram card that replays bus steps and checks ramdis and rdata
module tb_ram512k_card;
   timeunit 1ns;
   timeprecision 1ps;

   // step kinds
   localparam logic [2:0] K_IDLE      = 3'd0;
   localparam logic [2:0] K_IO_WR     = 3'd1;
   localparam logic [2:0] K_MEM_WR    = 3'd2;
   localparam logic [2:0] K_MEM_RD    = 3'd3;
   localparam logic [2:0] K_NOMREQ_WR = 3'd4;   // wr_b low and mreq_b high

   typedef struct packed {
      logic [2:0]  kind;
      logic [15:0] adr;
      logic [7:0]  data;
      logic        exp_dis;
      logic [7:0]  exp_rd;
   } step_t;

   logic        clk;
   logic        reset_b;
   logic [15:0] adr;
   logic        iorq_b;
   logic        mreq_b;
   logic        ramrd_b;
   logic        rd_b;
   logic        wr_b;
   logic [7:0]  data;
   logic [7:0]  rdata;
   logic        ramdis;

   step_t                  steps [$];
   logic [31:0]            rng;                              // xorshift state
   ram512k_pkg::bank_t     m_bank;                           // model copy of the config
   ram512k_pkg::scheme_t   m_scheme;
   logic [7:0]             shadow [ram512k_pkg::sram_adr_t]; // bytes written so far

   tb_clock_gen u_clk (.clk(clk), .reset_b(reset_b));

   ram512k_card uut
   (
      .clk     (clk),
      .reset_b (reset_b),
      .adr     (adr),
      .iorq_b  (iorq_b),
      .mreq_b  (mreq_b),
      .ramrd_b (ramrd_b),
      .rd_b    (rd_b),
      .wr_b    (wr_b),
      .data    (data),
      .rdata   (rdata),
      .ramdis  (ramdis)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_byte(output logic [7:0] b);
      rng = xorshift32(rng);
      b   = rng[7:0];
   endtask

   // does the expansion take this cpu address under the model config
   function automatic logic maps(input logic [15:0] a);
      logic hit;
      if (m_scheme == ram512k_pkg::SCHEME_OFF)
         hit = 1'b0;
      else if (m_scheme == ram512k_pkg::SCHEME_ALL)
         hit = 1'b1;
      else if (m_scheme == ram512k_pkg::SCHEME_TOP || m_scheme == ram512k_pkg::SCHEME_TOP_ALT)
         hit = (a[15:14] == 2'b11);
      else
         hit = (a[15:14] == 2'b01);                 // 0x4000 window
      return hit;
   endfunction

   // sram byte address that a mapped access reaches
   function automatic ram512k_pkg::sram_adr_t sram_index(input logic [15:0] a);
      logic [1:0] blk;
      logic [2:0] ofs;
      ofs = m_scheme - ram512k_pkg::WINDOW_BASE;
      if (m_scheme == ram512k_pkg::SCHEME_ALL)
         blk = a[15:14];
      else if (m_scheme == ram512k_pkg::SCHEME_TOP || m_scheme == ram512k_pkg::SCHEME_TOP_ALT)
         blk = 2'd3;
      else
         blk = ofs[1:0];                            // block is scheme minus 4
      return {m_bank, blk, a[13:0]};
   endfunction

   function automatic logic [15:0] quarter_adr(input logic [1:0] q);
      return {q, 14'h0155};
   endfunction

   task automatic add_step(input logic [2:0] k, input logic [15:0] a, input logic [7:0] d,
                           input logic dis, input logic [7:0] rd);
      step_t s;
      s.kind    = k;
      s.adr     = a;
      s.data    = d;
      s.exp_dis = dis;
      s.exp_rd  = rd;
      steps.push_back(s);
   endtask

   task automatic add_io_wr(input logic [15:0] a, input logic [7:0] d);
      add_step(K_IO_WR, a, d, maps(a), 8'h00);      // old config still applies this cycle
      if (!a[15] && d[7:6] == 2'b11)
      begin
         m_bank   = d[5:3];
         m_scheme = d[2:0];
      end
   endtask

   task automatic add_mem_wr(input logic [15:0] a, input logic [7:0] d);
      add_step(K_MEM_WR, a, d, maps(a), 8'h00);
      if (maps(a))
         shadow[sram_index(a)] = d;
   endtask

   task automatic add_nomreq_wr(input logic [15:0] a, input logic [7:0] d);
      add_step(K_NOMREQ_WR, a, d, maps(a), 8'h00);  // no chip select so nothing lands
   endtask

   task automatic add_mem_rd(input logic [15:0] a);
      logic [7:0] exp_v;
      exp_v = 8'h00;                                // unmapped reads see zero
      if (maps(a))
      begin
         if (!shadow.exists(sram_index(a)))
         begin
            $display("stimulus table reads an sram byte that was never written");
            $display("Errors found");
            $fatal(1, "bad stimulus table");
         end
         exp_v = shadow[sram_index(a)];
      end
      add_step(K_MEM_RD, a, 8'h00, maps(a), exp_v);
   endtask

   task automatic select_bank(input ram512k_pkg::bank_t b, input ram512k_pkg::scheme_t s);
      add_io_wr(16'h7f00, {2'b11, b, s});
   endtask

   task automatic drive_step(input step_t s);
      adr     = s.adr;
      data    = s.data;
      iorq_b  = !(s.kind == K_IO_WR);
      mreq_b  = !(s.kind == K_MEM_WR || s.kind == K_MEM_RD);
      ramrd_b = !(s.kind == K_MEM_RD);
      rd_b    = !(s.kind == K_MEM_RD);
      wr_b    = !(s.kind == K_IO_WR || s.kind == K_MEM_WR || s.kind == K_NOMREQ_WR);
   endtask

   task automatic check_step(input int idx, input step_t s);
      assert (ramdis === s.exp_dis)
      else
      begin
         $display("[ERROR] step %0d ramdis expected %h got %h", idx, s.exp_dis, ramdis);
         $display("Errors found");
         $fatal(1, "ramdis mismatch");
      end
      assert (rdata === s.exp_rd)
      else
      begin
         $display("[ERROR] step %0d rdata expected %h got %h", idx, s.exp_rd, rdata);
         $display("Errors found");
         $fatal(1, "rdata mismatch");
      end
   endtask

   // watchdog far beyond the length of the table
   initial
   begin
      #50000;
      $display("simulation did not finish within the time limit");
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      logic [7:0] b0 [0:3];
      logic [7:0] byte_v;
      logic [7:0] old_v;
      int         waited;
      adr      = '0;
      iorq_b   = 1'b1;
      mreq_b   = 1'b1;
      ramrd_b  = 1'b1;
      rd_b     = 1'b1;
      wr_b     = 1'b1;
      data     = '0;
      rng      = 32'd11;
      m_bank   = '0;
      m_scheme = ram512k_pkg::SCHEME_OFF;           // state after reset

      for (int q = 0; q < 4; q++)
         add_mem_rd(quarter_adr(2'(q)));           // card off the bus after reset
      add_io_wr(16'h7f00, {2'b10, 3'd1, ram512k_pkg::SCHEME_ALL});   // wrong tag
      add_io_wr(16'hff00, {2'b11, 3'd1, ram512k_pkg::SCHEME_ALL});   // a15 high
      add_mem_wr(16'h7f00, {2'b11, 3'd1, ram512k_pkg::SCHEME_ALL});  // memory write instead of i/o
      for (int q = 0; q < 4; q++)
         add_mem_rd(quarter_adr(2'(q)));

      select_bank(3'd0, ram512k_pkg::SCHEME_ALL);
      for (int q = 0; q < 4; q++)
      begin
         next_byte(byte_v);
         b0[q] = byte_v;
         add_mem_wr(quarter_adr(2'(q)), byte_v);
      end
      select_bank(3'd5, ram512k_pkg::SCHEME_ALL);
      for (int q = 0; q < 4; q++)
      begin
         next_byte(byte_v);
         if (byte_v == b0[q])
            byte_v = ~byte_v;                       // bank 5 must differ from bank 0
         add_mem_wr(quarter_adr(2'(q)), byte_v);
      end
      for (int q = 0; q < 4; q++)
         add_mem_rd(quarter_adr(2'(q)));
      select_bank(3'd0, ram512k_pkg::SCHEME_ALL);
      for (int q = 0; q < 4; q++)
         add_mem_rd(quarter_adr(2'(q)));

      select_bank(3'd5, ram512k_pkg::SCHEME_TOP);
      for (int q = 0; q < 4; q++)
         add_mem_rd(quarter_adr(2'(q)));           // only 0xc000 hits block 3
      select_bank(3'd0, ram512k_pkg::SCHEME_TOP_ALT);
      add_mem_rd(16'hc155);

      for (int s = 4; s < 8; s++)
      begin
         select_bank(3'd5, 3'(s));
         add_mem_rd(16'h4155);                      // window onto block s-4
         add_mem_rd(16'hc155);
      end

      select_bank(3'd0, ram512k_pkg::SCHEME_ALL);
      old_v = shadow[sram_index(16'h8155)];
      add_nomreq_wr(16'h8155, old_v ^ 8'h5a);
      add_mem_rd(16'h8155);                         // old byte survives
      add_mem_wr(16'h8155, old_v ^ 8'h5a);
      add_mem_rd(16'h8155);
      add_step(K_IDLE, 16'h0000, 8'h00, maps(16'h0000), 8'h00);

      waited = 0;
      while (reset_b !== 1'b1 && waited < 10)
      begin
         @(posedge clk);
         waited++;
      end
      if (reset_b !== 1'b1)
      begin
         $display("reset_b was never released");
         $display("Errors found");
         $fatal(1, "reset timeout");
      end

      for (int i = 0; i < steps.size(); i++)
      begin
         @(negedge clk);
         drive_step(steps[i]);
         #5;                                        // settled well before the rising edge
         check_step(i, steps[i]);
      end

      @(negedge clk);
      drive_step(step_t'{K_IDLE, 16'h0000, 8'h00, 1'b0, 8'h00});
      $display("No errors");
      $finish;
   end

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset source, 20 ns clock with reset_b held low for the first two edges
module tb_clock_gen
(
   output logic clk,
   output logic reset_b
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;         // 20 ns period
   end

   initial
   begin
      reset_b = 1'b0;
      repeat (2) @(posedge clk);      // two sampling edges in reset
      @(negedge clk);
      reset_b = 1'b1;                 // release away from the sampling edge
   end

endmodule

// ==== logic/ram512k_card.sv ====
// card top, cpld logic plus the 512k sram, presents the cpc bus to the testbench
module ram512k_card
(
   input  logic        clk,
   input  logic        reset_b,
   input  logic [15:0] adr,
   input  logic        iorq_b,
   input  logic        mreq_b,
   input  logic        ramrd_b,
   input  logic        rd_b,      // on the edge connector, the cpld never looks at it
   input  logic        wr_b,
   input  logic [7:0]  data,
   output logic [7:0]  rdata,
   output logic        ramdis
);

   ram512k_pkg::ramadrhi_t ramadrhi;
   ram512k_pkg::sram_adr_t sram_adr;
   logic                   ramcs_b;
   logic                   ramoe_b;
   logic                   ramwe_b;

   // high bits from the cpld, low 14 straight off the cpu
   assign sram_adr = {ramadrhi, adr[ram512k_pkg::ADR_LO_W-1:0]};

   cpld_ram512k u_cpld
   (
      .clk      (clk),
      .reset_b  (reset_b),
      .adr15    (adr[15]),
      .adr14    (adr[14]),
      .iorq_b   (iorq_b),
      .mreq_b   (mreq_b),
      .ramrd_b  (ramrd_b),
      .wr_b     (wr_b),
      .data     (data),
      .ramdis   (ramdis),
      .ramcs_b  (ramcs_b),
      .ramadrhi (ramadrhi),
      .ramoe_b  (ramoe_b),
      .ramwe_b  (ramwe_b)
   );

   sram_512k u_sram
   (
      .clk   (clk),
      .adr   (sram_adr),
      .wdata (data),        // write data shares the cpu data bus
      .cs_b  (ramcs_b),
      .oe_b  (ramoe_b),
      .we_b  (ramwe_b),
      .rdata (rdata)
   );

endmodule

// ==== logic/sram_512k.sv ====
// behavioural 512k x 8 static ram, clocked write and gated combinational read
module sram_512k
(
   input  logic                   clk,
   input  ram512k_pkg::sram_adr_t adr,
   input  logic [7:0]             wdata,
   input  logic                   cs_b,
   input  logic                   oe_b,
   input  logic                   we_b,
   output logic [7:0]             rdata
);

   logic [7:0] mem [0:ram512k_pkg::SRAM_DEPTH-1];   // byte array, no reset
   logic       rd_en;
   logic       wr_en;

   assign wr_en = !cs_b && !we_b;
   assign rd_en = !cs_b && !oe_b;

   // write lands on the sampling edge
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[adr] <= wdata;
      end
   end

   // zero when deselected so the bus model sees a clean value
   always_comb
   begin
      if (rd_en)
      begin
         rdata = mem[adr];
      end
      else
      begin
         rdata = 8'h00;
      end
   end

   // a z80 never reads and writes in one cycle
   a_no_rd_wr : assert property (
      @(posedge clk) !(rd_en && wr_en)
   ) else $error("sram_512k oe_b and we_b low together");

endmodule

// ==== logic/cpld_ram512k.sv ====
// cpld top for the 512k card, register plus mapper with ram strobes and internal ram disable
module cpld_ram512k
(
   input  logic                   clk,
   input  logic                   reset_b,
   input  logic                   adr15,
   input  logic                   adr14,
   input  logic                   iorq_b,
   input  logic                   mreq_b,
   input  logic                   ramrd_b,
   input  logic                   wr_b,
   input  logic [7:0]             data,
   output logic                   ramdis,     // high kills the cpc internal ram
   output logic                   ramcs_b,
   output ram512k_pkg::ramadrhi_t ramadrhi,
   output logic                   ramoe_b,
   output logic                   ramwe_b
);

   ram512k_pkg::bank_t   bank;
   ram512k_pkg::scheme_t scheme;
   logic                 sel;

   bank_select_reg u_bank_reg
   (
      .clk     (clk),
      .reset_b (reset_b),
      .iorq_b  (iorq_b),
      .wr_b    (wr_b),
      .adr15   (adr15),
      .data    (data),
      .bank    (bank),
      .scheme  (scheme)
   );

   block_mapper u_mapper
   (
      .bank     (bank),
      .scheme   (scheme),
      .adr15    (adr15),
      .adr14    (adr14),
      .sel      (sel),
      .ramadrhi (ramadrhi)
   );

   assign ramcs_b = !(sel && !mreq_b);   // chip select only on a real memory cycle
   assign ramdis  = sel;                 // disable held regardless of mreq
   assign ramoe_b = ramrd_b;             // cpc ramrd already qualifies reads
   assign ramwe_b = wr_b;

   // a selected sram must always have the internal ram off the bus
   a_cs_implies_dis : assert property (
      @(posedge clk) disable iff (!reset_b)
      !ramcs_b |-> ramdis
   ) else $error("cpld_ram512k ramcs_b low with ramdis low");

endmodule

// ==== logic/block_mapper.sv ====
// combinational block mapper, turns scheme, bank and a15:a14 into the card select and high ram address
module block_mapper
(
   input  ram512k_pkg::bank_t     bank,
   input  ram512k_pkg::scheme_t   scheme,
   input  logic                   adr15,
   input  logic                   adr14,
   output logic                   sel,        // expansion takes this access
   output ram512k_pkg::ramadrhi_t ramadrhi    // {bank, block}, zero when unmapped
);

   logic [ram512k_pkg::BLOCK_W-1:0] quarter;   // which 16k quarter of cpu space
   logic [ram512k_pkg::BLOCK_W-1:0] blk;       // block inside the bank
   logic [ram512k_pkg::BLOCK_W-1:0] win_blk;   // block for the 0x4000 window schemes
   ram512k_pkg::scheme_t            win_ofs;   // scheme minus window base
   logic                            hit;

   assign quarter = {adr15, adr14};

   // schemes 4..7 map onto blocks 0..3, only the low bits survive
   assign win_ofs = scheme - ram512k_pkg::WINDOW_BASE;
   assign win_blk = win_ofs[ram512k_pkg::BLOCK_W-1:0];

   always_comb
   begin
      hit = 1'b0;
      blk = '0;
      case (scheme)
         ram512k_pkg::SCHEME_OFF:
         begin
            hit = 1'b0;                    // cpc internal ram everywhere
         end
         ram512k_pkg::SCHEME_ALL:
         begin
            hit = 1'b1;                    // all four quarters
            blk = quarter;                 // block follows the cpu address
         end
         ram512k_pkg::SCHEME_TOP,
         ram512k_pkg::SCHEME_TOP_ALT:
         begin
            hit = (quarter == 2'b11);      // 0xc000 only
            blk = 2'b11;
         end
         default:
         begin
            // window schemes, 0x4000 quarter only
            hit = (quarter == 2'b01);
            blk = win_blk;
         end
      endcase
   end

   assign sel      = hit;
   assign ramadrhi = hit ? {bank, blk} : '0;   // unmapped drives zero, not x

   // scheme 0 must never pull the expansion onto the bus
   always_comb
   begin
      a_off_no_sel : assert ((scheme != ram512k_pkg::SCHEME_OFF) || !sel)
         else $error("block_mapper sel high with SCHEME_OFF");
   end

endmodule

// ==== logic/bank_select_reg.sv ====
// bank select register, snoops i/o writes to 0x7fxx and holds the current bank and scheme
module bank_select_reg
(
   input  logic                 clk,
   input  logic                 reset_b,     // sync, active low
   input  logic                 iorq_b,
   input  logic                 wr_b,
   input  logic                 adr15,       // port decode only looks at a15 low
   input  logic [7:0]           data,
   output ram512k_pkg::bank_t   bank,
   output ram512k_pkg::scheme_t scheme
);

   logic sel_evt;   // qualified select write this cycle

   // i/o write, a15 low and the 11 tag in the top data bits
   assign sel_evt = !iorq_b && !wr_b && !adr15 &&
                    (data[7:6] == ram512k_pkg::SELECT_TAG);

   // data[5:3] picks the bank, data[2:0] the scheme
   always_ff @(posedge clk)
   begin
      if (!reset_b)
      begin
         bank   <= '0;
         scheme <= '0;                      // SCHEME_OFF, card stays off the bus
      end
      else if (sel_evt)
      begin
         bank   <= data[5:3];
         scheme <= data[2:0];
      end
   end

   // the config only moves out of reset when a select write was seen the edge before
   a_change_needs_select : assert property (
      @(posedge clk) disable iff (!reset_b)
      (({bank, scheme} != $past({bank, scheme})) && $past(reset_b)) |-> $past(sel_evt)
   ) else $error("bank_select_reg config changed without a select write");

endmodule

// ==== logic/ram512k_pkg.sv ====
// shared widths, field types and scheme codes for the 512k ram card, referenced by package::name
package ram512k_pkg;

   // field widths
   localparam int BANK_W     = 3;                 // eight 64k banks
   localparam int SCHEME_W   = 3;                 // eight block switching schemes
   localparam int BLOCK_W    = 2;                 // four 16k blocks per bank
   localparam int RAMADRHI_W = BANK_W + BLOCK_W;  // bank and block together
   localparam int ADR_LO_W   = 14;                // byte offset inside a 16k block

   typedef logic [BANK_W-1:0]              bank_t;
   typedef logic [SCHEME_W-1:0]            scheme_t;
   typedef logic [RAMADRHI_W-1:0]          ramadrhi_t;
   typedef logic [RAMADRHI_W+ADR_LO_W-1:0] sram_adr_t;   // 19 bits, full byte address

   // 512k bytes in the external array
   localparam int SRAM_DEPTH = 524288;

   // top two data bits of a bank select write to 0x7fxx
   localparam logic [1:0] SELECT_TAG = 2'b11;

   // block switching schemes within the chosen bank
   localparam scheme_t SCHEME_OFF     = 3'd0;     // internal ram only
   localparam scheme_t SCHEME_TOP     = 3'd1;     // 0xc000 quarter to block 3
   localparam scheme_t SCHEME_ALL     = 3'd2;     // whole 64k from the bank
   localparam scheme_t SCHEME_TOP_ALT = 3'd3;     // same map as SCHEME_TOP on this card
   // schemes 4 to 7 put block (scheme - 4) in the 0x4000 window
   localparam scheme_t WINDOW_BASE    = 3'd4;

endpackage
